// File: verilog/scaler_pkg.sv
package scaler_pkg;

    // pixel and coefficient formats
    localparam int DATA_WIDTH  = 8;
    localparam int COEFF_WIDTH = 10;
    localparam int PIX_MAX     = (1 << DATA_WIDTH) - 1;

    // line positions, 4.12 fixed point
    localparam int STEP_WIDTH  = 16;
    localparam int PIXEL_STEP  = 4096;
    localparam int POS_WIDTH   = 24;

    // table index taken from position bits 11..4
    localparam int PHASE_BITS  = 8;
    localparam int PHASE_LSB   = 4;
    localparam int PHASES      = 1 << PHASE_BITS;

    // filter datapath
    localparam int TAPS        = 4;
    localparam int PIPE_STAGES = 4;
    localparam int MUL_WIDTH   = COEFF_WIDTH + DATA_WIDTH;
    localparam int SUM_WIDTH   = MUL_WIDTH + 2;
    localparam int FRAC_BITS   = COEFF_WIDTH - 1;
    localparam int ROUND_CONST = 1 << (FRAC_BITS - 1);

    // output side
    localparam int FIFO_DEPTH   = 16;
    localparam int PTR_WIDTH    = $clog2(FIFO_DEPTH);
    localparam int OUT_CREDITS  = 4;
    localparam int CREDIT_WIDTH = $clog2(OUT_CREDITS + 1);

    // one stream beat, at most one of de, hs, vs set
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  de;
        logic                  hs;
        logic                  vs;
    } video_beat_t;

    // weight magnitudes, lanes 0 and 3 are subtracted
    typedef struct packed {
        logic [COEFF_WIDTH-1:0] f0;
        logic [COEFF_WIDTH-1:0] f1;
        logic [COEFF_WIDTH-1:0] f2;
        logic [COEFF_WIDTH-1:0] f3;
    } coe_t;

    // catmull-rom weights for t = phase/256, 512 is unity
    // numerators are scaled by 2^24 and rounded to nearest
    function automatic coe_t coe_for_phase(input int phase);
        longint p;
        longint half;
        longint n0;
        longint n1;
        longint n2;
        longint n3;
        coe_t   c;

        p    = longint'(phase);
        half = 64'sd1 <<< 23;

        // 0.5t - t^2 + 0.5t^3
        n0 = (p <<< 24) - 131072 * p * p + 256 * p * p * p;
        // 1 - 2.5t^2 + 1.5t^3
        n1 = (64'sd1 <<< 33) - 327680 * p * p + 768 * p * p * p;
        // 0.5t + 2t^2 - 1.5t^3
        n2 = (p <<< 24) + 262144 * p * p - 768 * p * p * p;
        // magnitude of -0.5t^2 + 0.5t^3
        n3 = 65536 * p * p - 256 * p * p * p;

        c.f0 = COEFF_WIDTH'((n0 + half) >>> 24);
        c.f1 = COEFF_WIDTH'((n1 + half) >>> 24);
        c.f2 = COEFF_WIDTH'((n2 + half) >>> 24);
        c.f3 = COEFF_WIDTH'((n3 + half) >>> 24);
        return c;
    endfunction

endpackage

// File: verilog/scaler_coe.sv
`timescale 1ns/1ps

module scaler_coe (
    input  logic                              clk,
    input  logic [scaler_pkg::PHASE_BITS-1:0] phase_i,
    output scaler_pkg::coe_t                  coe_o
);

    import scaler_pkg::*;

    // weight set per phase
    // lane f0 pairs with the oldest tap, f3 with the newest
    coe_t rom [PHASES];

    // constant contents, evaluated at elaboration
    for (genvar g = 0; g < PHASES; g++) begin : g_rom
        assign rom[g] = coe_for_phase(g);
    end

    // registered lookup, weights follow the phase by one cycle
    always_ff @(posedge clk) begin
        coe_o <= rom[phase_i];
    end

endmodule

// File: verilog/scaler_h.sv
`timescale 1ns/1ps

module scaler_h (
    input  logic                              clk,
    input  logic                              rst,
    input  scaler_pkg::video_beat_t           beat_i,
    input  logic [scaler_pkg::STEP_WIDTH-1:0] scale_step_i,
    output scaler_pkg::video_beat_t           beat_o
);

    import scaler_pkg::*;

    // positions along the line
    logic [POS_WIDTH-1:0]        cnt_i;
    logic [POS_WIDTH-1:0]        cnt_o;

    // four newest pixels, win[0] oldest and win[TAPS-1] newest
    logic [DATA_WIDTH-1:0]       win [TAPS];

    logic                        sync_in;
    logic                        issue;

    // stage 0, captured window and phase
    logic [DATA_WIDTH-1:0]       tap_q [TAPS];
    logic [PHASE_BITS-1:0]       phase_q;

    // stage 1, weights and realigned taps
    coe_t                        coe_q;
    logic [COEFF_WIDTH-1:0]      coe_lane [TAPS];
    logic [DATA_WIDTH-1:0]       tap_d [TAPS];

    // stage 2 products, stage 3 signed sum
    logic [MUL_WIDTH-1:0]        mult_q [TAPS];
    logic signed [SUM_WIDTH-1:0] sum_q;
    logic [DATA_WIDTH-1:0]       pix_clamp;

    // beat markers {de, hs, vs}, one entry per stage
    logic [2:0]                  mk_q [PIPE_STAGES];

    // output register
    logic [DATA_WIDTH-1:0]       data_q;
    logic [2:0]                  flags_q;

    assign sync_in = beat_i.hs | beat_i.vs;

    // a sync takes the pipeline slot, so no event that cycle
    assign issue = (cnt_i > cnt_o) && !sync_in;

    // position counters and tap window
    always_ff @(posedge clk) begin
        if (rst || sync_in) begin
            cnt_i <= '0;
            cnt_o <= '0;
            for (int j = 0; j < TAPS; j++) begin
                win[j] <= '0;
            end
        end else begin
            if (beat_i.de) begin
                cnt_i <= cnt_i + POS_WIDTH'(PIXEL_STEP);
                for (int j = 0; j < TAPS - 1; j++) begin
                    win[j] <= win[j+1];
                end
                win[TAPS-1] <= beat_i.data;
            end
            if (issue) begin
                cnt_o <= cnt_o + POS_WIDTH'(scale_step_i);
            end
        end
    end

    // phase is taken before cnt_o advances
    always_ff @(posedge clk) begin
        if (issue) begin
            tap_q   <= win;
            phase_q <= cnt_o[PHASE_LSB +: PHASE_BITS];
        end
    end

    scaler_coe u_coe (
        .clk     (clk),
        .phase_i (phase_q),
        .coe_o   (coe_q)
    );

    assign coe_lane[0] = coe_q.f0;
    assign coe_lane[1] = coe_q.f1;
    assign coe_lane[2] = coe_q.f2;
    assign coe_lane[3] = coe_q.f3;

    // multiply-accumulate, runs every cycle
    always_ff @(posedge clk) begin
        tap_d <= tap_q;
        for (int j = 0; j < TAPS; j++) begin
            mult_q[j] <= coe_lane[j] * tap_d[j];
        end
        // outer lanes carry negative weights
        sum_q <= SUM_WIDTH'(mult_q[1]) + SUM_WIDTH'(mult_q[2])
               - SUM_WIDTH'(mult_q[0]) - SUM_WIDTH'(mult_q[3])
               + SUM_WIDTH'(ROUND_CONST);
    end

    // clamp to the pixel range
    always_comb begin
        if (sum_q[SUM_WIDTH-1]) begin
            pix_clamp = '0;
        end else if (|sum_q[SUM_WIDTH-2:FRAC_BITS+DATA_WIDTH]) begin
            pix_clamp = DATA_WIDTH'(PIX_MAX);
        end else begin
            pix_clamp = sum_q[FRAC_BITS +: DATA_WIDTH];
        end
    end

    // markers ride alongside the data, several events may be in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < PIPE_STAGES; k++) begin
                mk_q[k] <= '0;
            end
            flags_q <= '0;
        end else begin
            mk_q[0] <= {issue, beat_i.hs, beat_i.vs};
            for (int k = 1; k < PIPE_STAGES; k++) begin
                mk_q[k] <= mk_q[k-1];
            end
            flags_q <= mk_q[PIPE_STAGES-1];
        end
    end

    // sync and idle beats carry zero data
    always_ff @(posedge clk) begin
        data_q <= mk_q[PIPE_STAGES-1][2] ? pix_clamp : '0;
    end

    assign beat_o = '{data: data_q, de: flags_q[2], hs: flags_q[1], vs: flags_q[0]};

endmodule

// File: verilog/scaler_out_fifo.sv
`timescale 1ns/1ps

module scaler_out_fifo (
    input  logic                    clk,
    input  logic                    rst,
    input  scaler_pkg::video_beat_t beat_i,
    input  logic                    credit_i,
    output scaler_pkg::video_beat_t beat_o,
    output logic                    valid_o,
    output logic                    overflow_o
);

    import scaler_pkg::*;

    video_beat_t             mem [FIFO_DEPTH];

    // pointers carry one wrap bit to tell full from empty
    logic [PTR_WIDTH:0]      wr_ptr;
    logic [PTR_WIDTH:0]      rd_ptr;

    // credits granted by the sink and not yet used
    logic [CREDIT_WIDTH-1:0] credit_cnt;
    logic [CREDIT_WIDTH-1:0] credit_next;

    logic                    push;
    logic                    pop;
    logic                    full;
    logic                    empty;

    // any flagged beat is stored, idle beats are not
    assign push = beat_i.de | beat_i.hs | beat_i.vs;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_WIDTH] != rd_ptr[PTR_WIDTH]) &&
                   (wr_ptr[PTR_WIDTH-1:0] == rd_ptr[PTR_WIDTH-1:0]);

    // a transfer needs a stored beat and a credit in hand
    assign valid_o = (credit_cnt != '0) && !empty;
    assign pop     = valid_o;

    // head of the queue, flags held low between transfers
    assign beat_o = valid_o ? mem[rd_ptr[PTR_WIDTH-1:0]] : '0;

    always_ff @(posedge clk) begin
        if (push && !full) begin
            mem[wr_ptr[PTR_WIDTH-1:0]] <= beat_i;
        end
    end

    // spend one credit per transfer, take one back per credit_i
    always_comb begin
        credit_next = credit_cnt;
        if (pop) begin
            credit_next = credit_next - 1'b1;
        end
        // returns beyond the initial grant are ignored
        if (credit_i && credit_next != CREDIT_WIDTH'(OUT_CREDITS)) begin
            credit_next = credit_next + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            credit_cnt <= CREDIT_WIDTH'(OUT_CREDITS);
            overflow_o <= 1'b0;
        end else begin
            if (push) begin
                if (full) begin
                    // source cannot stall, beat is lost
                    overflow_o <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            credit_cnt <= credit_next;
        end
    end

endmodule

// File: verilog/scaler_top.sv
`timescale 1ns/1ps

module scaler_top (
    input  logic                              clk,
    input  logic                              rst,

    // source stream, never stalled
    input  scaler_pkg::video_beat_t           in_beat_i,
    // 4.12 step, held between hs pulses
    input  logic [scaler_pkg::STEP_WIDTH-1:0] scale_step_i,

    // sink side
    input  logic                              credit_i,
    output scaler_pkg::video_beat_t           out_beat_o,
    output logic                              out_valid_o,
    output logic                              overflow_o
);

    import scaler_pkg::*;

    // resampled beats, one per cycle at most
    video_beat_t h_beat;

    scaler_h u_scaler_h (
        .clk          (clk),
        .rst          (rst),
        .beat_i       (in_beat_i),
        .scale_step_i (scale_step_i),
        .beat_o       (h_beat)
    );

    scaler_out_fifo u_out_fifo (
        .clk        (clk),
        .rst        (rst),
        .beat_i     (h_beat),
        .credit_i   (credit_i),
        .beat_o     (out_beat_o),
        .valid_o    (out_valid_o),
        .overflow_o (overflow_o)
    );

endmodule

// File: tests/scaler_top_chk.sv
`timescale 1ns/1ps

module scaler_top_chk (
    input logic                                  clk,
    input logic                                  rst,
    input scaler_pkg::video_beat_t               h_beat_i,
    input scaler_pkg::video_beat_t               out_beat_i,
    input logic                                  out_valid_i,
    input logic                                  credit_i,
    input logic                                  overflow_i,
    input logic [scaler_pkg::CREDIT_WIDTH-1:0]   credit_cnt_i
);

    import scaler_pkg::*;

    // credits held by the FIFO, counted from the sink side
    int held;
    int held_next;

    always_comb begin
        held_next = held - int'(out_valid_i) + int'(credit_i);
        if (held_next > OUT_CREDITS) begin
            held_next = OUT_CREDITS;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= OUT_CREDITS;
        end else begin
            held <= held_next;
        end
    end

    // no transfer without a credit in hand
    assert property (@(posedge clk) disable iff (rst) out_valid_i |-> held > 0)
        else $error("out_valid_o high with no credit left");

    assert property (@(posedge clk) disable iff (rst)
                     credit_cnt_i <= CREDIT_WIDTH'(OUT_CREDITS))
        else $error("credit count above the initial grant");

    // at most one flag per beat
    assert property (@(posedge clk) disable iff (rst)
                     $onehot0({h_beat_i.de, h_beat_i.hs, h_beat_i.vs}))
        else $error("scaler beat with several flags");

    assert property (@(posedge clk) disable iff (rst)
                     $onehot0({out_beat_i.de, out_beat_i.hs, out_beat_i.vs}))
        else $error("output beat with several flags");

    // sticky until reset
    assert property (@(posedge clk) disable iff (rst)
                     $past(overflow_i) && !$past(rst) |-> overflow_i)
        else $error("overflow_o fell without reset");

endmodule

bind scaler_top scaler_top_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .h_beat_i     (h_beat),
    .out_beat_i   (out_beat_o),
    .out_valid_i  (out_valid_o),
    .credit_i     (credit_i),
    .overflow_i   (overflow_o),
    .credit_cnt_i (u_out_fifo.credit_cnt)
);

// File: tests/scaler_top_tb.sv
`timescale 1ns/1ps

module scaler_top_tb;

    import scaler_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int STEP_UNITY = 4096;
    localparam int STEP_DOWN  = 6144;
    localparam int STEP_UP    = 2731;

    // input beats per test, one hs per line plus the pixels
    localparam int TOTAL_BEATS = 2 * 21 + 4 * 21 + 2 * 17 + 1 + 3 * 13 + 3 * 25 + 31;
    // widest gap belongs to the upscale step
    localparam int MAX_GAP     = (STEP_UNITY + STEP_UP - 1) / STEP_UP + 1;
    localparam int WATCHDOG_NS = TOTAL_BEATS * MAX_GAP * CLK_PERIOD * 2;

    logic                  clk;
    logic                  rst;
    video_beat_t           in_beat;
    logic [STEP_WIDTH-1:0] scale_step;
    logic                  credit;
    video_beat_t           out_beat;
    logic                  out_valid;
    logic                  overflow;

    video_beat_t           exp_q [$];
    int                    errors;
    int                    checks;
    int                    test_errors;
    logic                  check_en;
    // 0 always return, 1 random gaps, 2 withhold
    int                    credit_mode;
    logic [31:0]           pix_seed;
    logic [31:0]           credit_seed;

    scaler_top u_scaler_top (
        .clk          (clk),
        .rst          (rst),
        .in_beat_i    (in_beat),
        .scale_step_i (scale_step),
        .credit_i     (credit),
        .out_beat_o   (out_beat),
        .out_valid_o  (out_valid),
        .overflow_o   (overflow)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected pixel from the four taps, p0 oldest and p3 newest
    function automatic int expected_pixel(input int p0, input int p1, input int p2,
                                          input int p3, input int phase);
        coe_t c;
        int   s;
        int   v;
        c = coe_for_phase(phase);
        s = int'(c.f1) * p1 + int'(c.f2) * p2 - int'(c.f0) * p0 - int'(c.f3) * p3 + 256;
        v = s >>> 9;
        if (v < 0) begin
            v = 0;
        end else if (v > 255) begin
            v = 255;
        end
        return v;
    endfunction

    // sink returns credits
    initial begin
        credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (credit_mode == 0) begin
                credit = 1'b1;
            end else if (credit_mode == 1) begin
                credit_seed = lcg(credit_seed);
                credit = credit_seed[16];
            end else begin
                credit = 1'b0;
            end
        end
    end

    // scoreboard
    always @(posedge clk) begin
        video_beat_t exp;
        if (!rst && out_valid && check_en) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t: output beat arrived with nothing expected", $time);
                errors++;
            end else begin
                exp = exp_q.pop_front();
                checks++;
                assert (out_beat == exp) else begin
                    $display("Fail at %0t: out_beat_o got %h expected %h", $time, out_beat, exp);
                    errors++;
                end
            end
        end
    end

    task automatic send_beat(input video_beat_t b, input int gap);
        @(posedge clk);
        #1;
        in_beat = b;
        repeat (gap) begin
            @(posedge clk);
            #1;
            in_beat = '0;
        end
    endtask

    // one line, hs first; mode 0 random pixels, mode 1 pairs of 0 and 255
    task automatic send_line(input int step, input int npix, input int mode);
        int          px [$];
        int          gap;
        int          k;
        int          t [4];
        video_beat_t b;
        gap = (STEP_UNITY + step - 1) / step + 1;
        scale_step = STEP_WIDTH'(step);
        b = '{data: '0, de: 1'b0, hs: 1'b1, vs: 1'b0};
        exp_q.push_back(b);
        send_beat(b, gap);
        k = 0;
        for (int n = 1; n <= npix; n++) begin
            if (mode == 0) begin
                pix_seed = lcg(pix_seed);
                px.push_back(int'(pix_seed[23:16]));
            end else begin
                px.push_back((((n - 1) / 2) % 2 == 1) ? 255 : 0);
            end
            while (longint'(k) * step < longint'(n) * STEP_UNITY) begin
                for (int j = 0; j < 4; j++) begin
                    t[j] = (n - 4 + j >= 0) ? px[n - 4 + j] : 0;
                end
                b.data = DATA_WIDTH'(expected_pixel(t[0], t[1], t[2], t[3],
                                                    ((k * step) % STEP_UNITY) / 16));
                b.de = 1'b1;
                b.hs = 1'b0;
                b.vs = 1'b0;
                exp_q.push_back(b);
                k++;
            end
            b = '{data: DATA_WIDTH'(px[n - 1]), de: 1'b1, hs: 1'b0, vs: 1'b0};
            send_beat(b, gap);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 2000) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Error: %0d expected beats never came out", exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (8) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        rst = 1'b1;
        in_beat = '0;
        scale_step = STEP_WIDTH'(STEP_UNITY);
        errors = 0;
        checks = 0;
        test_errors = 0;
        check_en = 1'b1;
        credit_mode = 0;
        pix_seed = 32'hd1e1_3ad3;
        credit_seed = 32'hd1e1_3ad3;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        send_line(STEP_UNITY, 20, 0);
        send_line(STEP_UNITY, 20, 0);
        drain();
        finish_test("unity");

        send_line(STEP_DOWN, 20, 0);
        send_line(STEP_DOWN, 20, 0);
        send_line(STEP_UP, 20, 0);
        send_line(STEP_UP, 20, 0);
        drain();
        finish_test("down_up");

        send_line(STEP_UP, 16, 1);
        send_line(STEP_UP, 16, 1);
        drain();
        finish_test("clamp");

        exp_q.push_back('{data: '0, de: 1'b0, hs: 1'b0, vs: 1'b1});
        send_beat('{data: '0, de: 1'b0, hs: 1'b0, vs: 1'b1}, 2);
        for (int i = 0; i < 3; i++) begin
            send_line(STEP_DOWN, 12, 0);
        end
        drain();
        finish_test("sync");

        credit_mode = 1;
        for (int i = 0; i < 3; i++) begin
            send_line(STEP_UNITY, 24, 0);
        end
        drain();
        assert (!overflow) else begin
            $display("Error: overflow_o rose while credits were returned");
            errors++;
        end
        finish_test("credit");

        // 31 beats against 4 credits and 16 entries
        credit_mode = 2;
        check_en = 1'b0;
        send_line(STEP_UNITY, 30, 0);
        repeat (10) @(posedge clk);
        assert (overflow) else begin
            $display("Error: overflow_o stayed low after the FIFO filled up");
            errors++;
        end
        credit_mode = 0;
        repeat (20) @(posedge clk);
        assert (overflow) else begin
            $display("Error: overflow_o fell without a reset");
            errors++;
        end
        #1;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!overflow) else begin
            $display("Error: overflow_o not cleared by reset");
            errors++;
        end
        exp_q.delete();
        finish_test("overflow");

        $display("%0d beats checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: scaler_top.f
verilog/scaler_pkg.sv
verilog/scaler_coe.sv
verilog/scaler_h.sv
verilog/scaler_out_fifo.sv
verilog/scaler_top.sv
tests/scaler_top_chk.sv
tests/scaler_top_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= scaler_top_tb
FILELIST  ?= scaler_top.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build products"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
